//--- Bender.yml
package:
  name: hbridge_ctrl

sources:
  # packages first, the modules import them
  - rtl/hb_types_pkg.sv
  - rtl/hb_timing_pkg.sv
  - rtl/tank_current_law.sv
  - rtl/startup_sequencer.sv
  - rtl/gate_driver.sv
  - rtl/hbridge_ctrl_top.sv
  - target: test
    files:
      - verification/hbridge_tb.sv

//--- rtl/gate_driver.sv
`timescale 1ns/1ns

module gate_driver (
   input  logic                  ADA_DCO,
   input  logic                  i_reset,
   input  hb_types_pkg::phase_e  i_phase,        // start-up phase
   input  hb_types_pkg::gates_t  i_pattern,      // law diagonal
   input  hb_types_pkg::dt_sel_t i_deadtime_sel, // dead-time switch
   output hb_types_pkg::gates_t  o_gates
);

   import hb_types_pkg::*;
   import hb_timing_pkg::*;

   gates_t     req;         // requested pattern
   logic [3:0] req_v;       // same, as a plain vector
   logic [3:0] out_q;       // delayed gates, before the guard
   gates_t     gates_q;
   cnt_t       dt_len;      // current dead time
   cnt_t       dt_cnt [4];  // per gate high-time counters
   logic       shoot;       // a leg would short

   // ------------------------------------------------------------------
   // request by phase
   // ------------------------------------------------------------------
   always_comb begin
      req = '0;
      case (i_phase)
         PH_BOOT: begin
            req.q3 = 1'b1; // low sides charge the bootstrap caps
            req.q4 = 1'b1;
         end
         PH_FORCE: begin
            req.q1 = 1'b1; // fixed diagonal, sigma = +1
            req.q4 = 1'b1;
         end
         PH_RUN: begin
            req = i_pattern;
         end
         default: begin
            req = '0; // idle, bridge off
         end
      endcase
   end

   assign req_v  = req;
   assign dt_len = DT_TABLE[i_deadtime_sel]; // read every cycle

   // ------------------------------------------------------------------
   // dead time, rising edges only
   // ------------------------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         out_q <= '0;
         for (int i = 0; i < 4; i++) begin
            dt_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (!req_v[i]) begin
               out_q[i]  <= 1'b0; // turn-off is immediate
               dt_cnt[i] <= '0;
            end else if (!out_q[i]) begin
               // >= so a shorter select releases a pending rise at once
               if (cnt_t'(dt_cnt[i] + 16'd1) >= dt_len) begin
                  out_q[i] <= 1'b1;
               end
               dt_cnt[i] <= dt_cnt[i] + 16'd1;
            end
         end
      end
   end

   assign gates_q = out_q;

   // ------------------------------------------------------------------
   // shoot-through guard
   // ------------------------------------------------------------------
   assign shoot = (gates_q.q1 & gates_q.q3) | // leg 1
                  (gates_q.q2 & gates_q.q4);  // leg 2

   assign o_gates = shoot ? gates_t'('0) : gates_q; // all off on a conflict

endmodule

//--- rtl/hb_timing_pkg.sv
package hb_timing_pkg;

   // ------------------------------------------------------------------
   // start-up defaults, in ADA_DCO cycles
   // ------------------------------------------------------------------
   localparam hb_types_pkg::cnt_t ON_CYCLES_DEF = 16'd1000; // end of bootstrap
   localparam hb_types_pkg::cnt_t VG_CYCLES_DEF = 16'd1600; // end of forced diagonal

   // ------------------------------------------------------------------
   // current law
   // ------------------------------------------------------------------
   localparam hb_types_pkg::sample_t HYST_DEF = 14'sd64; // half band, adc codes

   // ------------------------------------------------------------------
   // dead time table, indexed by the select switch
   // ------------------------------------------------------------------
   localparam hb_types_pkg::cnt_t DT_TABLE [4] = '{
      16'd10, // sel 0
      16'd20, // sel 1
      16'd40, // sel 2
      16'd60  // sel 3
   };

endpackage

//--- rtl/hb_types_pkg.sv
package hb_types_pkg;

   // ------------------------------------------------------------------
   // data widths
   // ------------------------------------------------------------------
   typedef logic signed [13:0] sample_t; // tank current, two's complement
   typedef logic [15:0]        cnt_t;    // start-up and dead-time counts
   typedef logic [1:0]         dt_sel_t; // dead-time select switch

   // gate word, one bit per MOSFET
   // leg 1: q1 high side, q3 low side
   // leg 2: q2 high side, q4 low side
   typedef struct packed {
      logic q1;
      logic q2;
      logic q3;
      logic q4;
   } gates_t;

   // ------------------------------------------------------------------
   // state machines
   // ------------------------------------------------------------------
   typedef enum logic [1:0] {
      PH_IDLE  = 2'd0, // bridge off
      PH_BOOT  = 2'd1, // both low sides on, bootstrap caps charging
      PH_FORCE = 2'd2, // q1+q4 forced to kick the tank
      PH_RUN   = 2'd3  // current law in charge
   } phase_e;

   typedef enum logic {
      SIGMA_NEG = 1'b0, // q2+q3 diagonal
      SIGMA_POS = 1'b1  // q1+q4 diagonal
   } sigma_e;

endpackage

//--- rtl/hbridge_ctrl_top.sv
`timescale 1ns/1ns

module hbridge_ctrl_top #(
   parameter hb_types_pkg::cnt_t    ON_CYCLES = hb_timing_pkg::ON_CYCLES_DEF,
   parameter hb_types_pkg::cnt_t    VG_CYCLES = hb_timing_pkg::VG_CYCLES_DEF,
   parameter hb_types_pkg::sample_t HYST      = hb_timing_pkg::HYST_DEF
) (
   input  logic                  ADA_DCO,        // adc data clock
   input  logic                  i_reset,
   input  logic                  i_enable,       // converter on
   input  hb_types_pkg::sample_t i_adc_data,     // tank current code
   input  logic                  i_adc_or,       // over-range
   input  hb_types_pkg::dt_sel_t i_deadtime_sel,
   output hb_types_pkg::gates_t  o_gates,        // q1..q4 to the gate drivers
   output hb_types_pkg::phase_e  o_phase
);

   import hb_types_pkg::*;

   gates_t pattern; // law diagonal
   phase_e phase;

   // ------------------------------------------------------------------
   // law and sequencer run side by side
   // ------------------------------------------------------------------
   tank_current_law #(
      .HYST (HYST)
   ) law_i (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_adc_data (i_adc_data),
      .i_adc_or   (i_adc_or),
      .o_pattern  (pattern)
   );

   startup_sequencer #(
      .ON_CYCLES (ON_CYCLES),
      .VG_CYCLES (VG_CYCLES)
   ) seq_i (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_enable (i_enable),
      .o_phase  (phase)
   );

   // driver merges both
   gate_driver drv_i (
      .ADA_DCO        (ADA_DCO),
      .i_reset        (i_reset),
      .i_phase        (phase),
      .i_pattern      (pattern),
      .i_deadtime_sel (i_deadtime_sel),
      .o_gates        (o_gates)
   );

   assign o_phase = phase;

endmodule

//--- rtl/startup_sequencer.sv
`timescale 1ns/1ns

module startup_sequencer #(
   parameter hb_types_pkg::cnt_t ON_CYCLES = hb_timing_pkg::ON_CYCLES_DEF,
   parameter hb_types_pkg::cnt_t VG_CYCLES = hb_timing_pkg::VG_CYCLES_DEF
) (
   input  logic                 ADA_DCO,
   input  logic                 i_reset,
   input  logic                 i_enable, // converter on
   output hb_types_pkg::phase_e o_phase
);

   import hb_types_pkg::*;

   phase_e phase_q;
   cnt_t   cnt_q;   // cycles since PH_BOOT began
   cnt_t   cnt_nxt;

   assign cnt_nxt = cnt_q + 16'd1;

   // ------------------------------------------------------------------
   // start-up fsm
   // ------------------------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_reset || !i_enable) begin
         phase_q <= PH_IDLE; // enable low restarts from scratch
         cnt_q   <= '0;
      end else begin
         case (phase_q)
            PH_IDLE: begin
               phase_q <= PH_BOOT;
               cnt_q   <= '0;
            end
            PH_BOOT: begin
               cnt_q <= cnt_nxt;
               if (cnt_nxt == ON_CYCLES) phase_q <= PH_FORCE; // caps charged
            end
            PH_FORCE: begin
               cnt_q <= cnt_nxt;
               if (cnt_nxt == VG_CYCLES) phase_q <= PH_RUN;
            end
            default: begin
               cnt_q <= cnt_q; // counter parks at VG_CYCLES
            end
         endcase
      end
   end

   assign o_phase = phase_q;

endmodule

//--- rtl/tank_current_law.sv
`timescale 1ns/1ns

module tank_current_law #(
   parameter hb_types_pkg::sample_t HYST = hb_timing_pkg::HYST_DEF
) (
   input  logic                  ADA_DCO,
   input  logic                  i_reset,
   input  hb_types_pkg::sample_t i_adc_data, // raw adc word
   input  logic                  i_adc_or,   // adc over-range flag
   output hb_types_pkg::gates_t  o_pattern   // diagonal requested by the law
);

   import hb_types_pkg::*;

   localparam sample_t S_MAX  = {1'b0, {13{1'b1}}}; // +8191
   localparam sample_t S_MIN  = {1'b1, {13{1'b0}}}; // -8192
   localparam sample_t HYST_N = -HYST;

   sample_t sample_c;  // conditioned code
   sample_t sample_q;  // registered sample
   sigma_e  sigma_q;   // switching state

   // ------------------------------------------------------------------
   // sample conditioning
   // ------------------------------------------------------------------
   // current sensor polarity is inverted on the board
   always_comb begin
      if (i_adc_or) begin
         // over-range, clamp to the rail the raw code points at
         sample_c = (i_adc_data == S_MIN) ? S_MAX : S_MIN;
      end else if (i_adc_data == S_MIN) begin
         sample_c = S_MAX; // -(-8192) does not fit
      end else begin
         sample_c = -i_adc_data;
      end
   end

   always_ff @(posedge ADA_DCO) begin
      sample_q <= sample_c; // one sample per dco edge
   end

   // ------------------------------------------------------------------
   // hysteresis sign law, phi = 0
   // ------------------------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         sigma_q <= SIGMA_NEG;
      end else if (sample_q > HYST) begin
         sigma_q <= SIGMA_POS;
      end else if (sample_q < HYST_N) begin
         sigma_q <= SIGMA_NEG;
      end
      // inside the band sigma holds
   end

   // diagonal decode
   always_comb begin
      o_pattern = '0;
      case (sigma_q)
         SIGMA_POS: begin
            o_pattern.q1 = 1'b1;
            o_pattern.q4 = 1'b1;
         end
         default: begin
            o_pattern.q2 = 1'b1;
            o_pattern.q3 = 1'b1;
         end
      endcase
   end

endmodule

//--- src.f
rtl/hb_types_pkg.sv
rtl/hb_timing_pkg.sv
rtl/tank_current_law.sv
rtl/startup_sequencer.sv
rtl/gate_driver.sv
rtl/hbridge_ctrl_top.sv
verification/hbridge_tb.sv

//--- verification/hbridge_tb.sv
`timescale 1ns/1ns

module hbridge_tb;

   import hb_types_pkg::*;
   import hb_timing_pkg::*;

   localparam cnt_t    ON_TB   = 16'd10;
   localparam cnt_t    VG_TB   = 16'd16;
   localparam sample_t HYST_TB = 14'sd64;
   localparam sample_t ADC_MIN = 14'sh2000; // most negative raw code

   // one row of stimulus plus the value expected after its last cycle
   typedef struct packed {
      logic       en;
      sample_t    adc;
      logic       ovr;
      dt_sel_t    sel;
      logic       rnd;   // fresh in-band code every cycle
      logic [7:0] hold;
      gates_t     gates;
      phase_e     phase;
   } row_t;

   logic    ADA_DCO = 1'b0;
   logic    i_reset, i_enable, i_adc_or;
   sample_t i_adc_data;
   dt_sel_t i_deadtime_sel;
   gates_t  o_gates;
   phase_e  o_phase;

   row_t   rows [$];
   int     n_mis   = 0;
   int     n_other = 0;
   logic   chk_on  = 1'b0;
   int     n;

   // reference model state
   sample_t    m_sample;
   logic       m_sigma = 1'b0;    // 1 = q1+q4 diagonal
   phase_e     m_phase = PH_IDLE;
   int         m_age   = 0;       // edges since boot began
   int         m_high [4];        // edges each request has been high
   logic [3:0] m_out   = '0;
   gates_t     m_gates = '0;

   hbridge_ctrl_top #(
      .ON_CYCLES (ON_TB),
      .VG_CYCLES (VG_TB),
      .HYST      (HYST_TB)
   ) dut_i (
      .ADA_DCO        (ADA_DCO),
      .i_reset        (i_reset),
      .i_enable       (i_enable),
      .i_adc_data     (i_adc_data),
      .i_adc_or       (i_adc_or),
      .i_deadtime_sel (i_deadtime_sel),
      .o_gates        (o_gates),
      .o_phase        (o_phase)
   );

   always #2 ADA_DCO = ~ADA_DCO; // 4 ns period

   // ------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------
   task automatic check_gates(input gates_t got, input gates_t exp, input string name);
      if (got !== exp) begin
         n_mis++;
         $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_phase(input phase_e got, input phase_e exp, input string name);
      if (got !== exp) begin
         n_mis++;
         $display("Mismatch at %0t ns: %s got %s expected %s", $time, name, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_count(input cnt_t got, input cnt_t exp, input string name);
      if (got !== exp) begin
         n_mis++;
         $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // ------------------------------------------------------------------
   // reference model, one update per edge
   // ------------------------------------------------------------------
   function automatic sample_t expected_sample(input sample_t raw, input logic ovr);
      int v;
      v = -int'(raw); // sensor polarity inverted
      if (ovr && raw != ADC_MIN) return ADC_MIN;
      if (v > 8191) return sample_t'(8191); // top rail
      return sample_t'(v);
   endfunction

   always @(posedge ADA_DCO) begin : model
      logic [3:0] req;
      int         dt;
      case (m_phase) // request seen before this edge
         PH_BOOT:  req = 4'b0011;
         PH_FORCE: req = 4'b1001;
         PH_RUN:   req = m_sigma ? 4'b1001 : 4'b0110;
         default:  req = 4'b0000;
      endcase
      dt = DT_TABLE[i_deadtime_sel];
      for (int i = 0; i < 4; i++) begin
         if (i_reset || !req[i]) begin
            m_out[i]  = 1'b0;
            m_high[i] = 0;
         end else begin
            m_high[i]++;
            if (m_high[i] >= dt) m_out[i] = 1'b1;
         end
      end
      if (i_reset) m_sigma = 1'b0;
      else if (int'(m_sample) > int'(HYST_TB)) m_sigma = 1'b1;
      else if (int'(m_sample) < -int'(HYST_TB)) m_sigma = 1'b0;
      m_sample = expected_sample(i_adc_data, i_adc_or);
      if (i_reset || !i_enable) begin
         m_phase = PH_IDLE;
         m_age   = 0;
      end else if (m_phase == PH_IDLE) begin
         m_phase = PH_BOOT;
      end else begin
         if (m_age < VG_TB) m_age++;
         m_phase = (m_age >= VG_TB) ? PH_RUN : (m_age >= ON_TB) ? PH_FORCE : PH_BOOT;
      end
      // a leg conflict blanks all four
      m_gates = ((m_out[3] & m_out[1]) | (m_out[2] & m_out[0])) ? gates_t'('0) : m_out;
   end

   always @(negedge ADA_DCO) begin
      if (chk_on) begin
         check_gates(o_gates, m_gates, "o_gates");
         check_phase(o_phase, m_phase, "o_phase");
         if ((o_gates.q1 && o_gates.q3) || (o_gates.q2 && o_gates.q4)) begin
            n_other++;
            $display("both gates of one leg are on at %0t ns", $time);
         end
      end
   end

   // ------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge ADA_DCO);
      #1; // inputs move 1 ns after the edge
   endtask

   function automatic sample_t in_band_code();
      return sample_t'(int'($urandom_range(128, 0)) - 64);
   endfunction

   function automatic void add_row(input logic en, input sample_t adc, input logic ovr,
                                   input dt_sel_t sel, input logic rnd, input int hold,
                                   input gates_t g, input phase_e ph);
      row_t r;
      r.en    = en;
      r.adc   = adc;
      r.ovr   = ovr;
      r.sel   = sel;
      r.rnd   = rnd;
      r.hold  = hold[7:0];
      r.gates = g;
      r.phase = ph;
      rows.push_back(r);
   endfunction

   task automatic set_inputs(input logic en, input sample_t adc, input logic ovr,
                             input dt_sel_t sel);
      i_enable       = en;
      i_adc_data     = adc;
      i_adc_or       = ovr;
      i_deadtime_sel = sel;
   endtask

   task automatic wait_phase(input phase_e ph, input int limit);
      int k;
      k = 0;
      while (o_phase !== ph && k < limit) begin
         next_cycle();
         k++;
      end
      if (o_phase !== ph) begin
         n_other++;
         $display("timeout: phase %s not reached within %0d cycles", ph.name(), limit);
      end
   endtask

   task automatic wait_gates(input gates_t target, input int limit, output int k);
      k = 0;
      while (o_gates !== target && k < limit) begin
         next_cycle();
         k++;
      end
      if (o_gates !== target) begin
         n_other++;
         $display("timeout: gates never reached %b within %0d cycles", target, limit);
      end
   endtask

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial begin
      void'($urandom(32'h05b0_9ce8));
      i_reset = 1'b1;
      set_inputs(1'b0, 14'sd0, 1'b0, 2'd0);
      // idle, then start-up with sigma pushed positive
      add_row(1'b0, 14'sd0,    1'b0, 2'd0, 1'b0,  8, 4'b0000, PH_IDLE);
      add_row(1'b1, -14'sd500, 1'b0, 2'd0, 1'b0, 11, 4'b0011, PH_FORCE);
      add_row(1'b1, -14'sd500, 1'b0, 2'd0, 1'b0,  6, 4'b0001, PH_RUN);
      add_row(1'b1, -14'sd500, 1'b0, 2'd0, 1'b0,  4, 4'b1001, PH_RUN);
      // sign law and band edges
      add_row(1'b1, -14'sd30,  1'b0, 2'd0, 1'b0,  5, 4'b1001, PH_RUN);
      add_row(1'b1, 14'sd0,    1'b0, 2'd0, 1'b1, 10, 4'b1001, PH_RUN);
      add_row(1'b1, 14'sd100,  1'b0, 2'd0, 1'b0,  3, 4'b0000, PH_RUN); // fall after 3
      add_row(1'b1, 14'sd100,  1'b0, 2'd0, 1'b0,  9, 4'b0110, PH_RUN);
      add_row(1'b1, 14'sd0,    1'b0, 2'd0, 1'b1, 10, 4'b0110, PH_RUN);
      add_row(1'b1, -14'sd64,  1'b0, 2'd0, 1'b0,  6, 4'b0110, PH_RUN);
      add_row(1'b1, -14'sd65,  1'b0, 2'd0, 1'b0,  3, 4'b0000, PH_RUN);
      add_row(1'b1, -14'sd65,  1'b0, 2'd0, 1'b0,  9, 4'b1001, PH_RUN);
      add_row(1'b1, 14'sd64,   1'b0, 2'd0, 1'b0,  6, 4'b1001, PH_RUN);
      // over-range
      add_row(1'b1, ADC_MIN,   1'b1, 2'd0, 1'b0,  6, 4'b1001, PH_RUN);
      add_row(1'b1, 14'sd100,  1'b1, 2'd0, 1'b0,  3, 4'b0000, PH_RUN);
      add_row(1'b1, 14'sd100,  1'b1, 2'd0, 1'b0,  9, 4'b0110, PH_RUN);
      add_row(1'b1, ADC_MIN,   1'b0, 2'd0, 1'b0, 12, 4'b1001, PH_RUN);
      add_row(1'b1, 14'sd5,    1'b1, 2'd0, 1'b0, 12, 4'b0110, PH_RUN);
      // enable drop, gates off 2 cycles later, then restart
      add_row(1'b0, 14'sd0,    1'b0, 2'd0, 1'b0,  1, 4'b0110, PH_IDLE);
      add_row(1'b0, 14'sd0,    1'b0, 2'd0, 1'b0,  1, 4'b0000, PH_IDLE);
      add_row(1'b0, 14'sd0,    1'b0, 2'd0, 1'b0,  4, 4'b0000, PH_IDLE);
      add_row(1'b1, -14'sd500, 1'b0, 2'd1, 1'b0,  1, 4'b0000, PH_BOOT);

      repeat (2) @(posedge ADA_DCO);
      #1;
      i_reset = 1'b0;
      chk_on  = 1'b1;

      foreach (rows[i]) begin
         for (int c = 0; c < rows[i].hold; c++) begin
            set_inputs(rows[i].en, rows[i].rnd ? in_band_code() : rows[i].adc,
                       rows[i].ovr, rows[i].sel);
            next_cycle();
         end
         check_gates(o_gates, rows[i].gates, "o_gates");
         check_phase(o_phase, rows[i].phase, "o_phase");
      end
      wait_phase(PH_FORCE, 20);
      wait_phase(PH_RUN, 20);

      // dead time per select, 2 cycles of law pipeline before the request
      for (int s = 0; s < 4; s++) begin
         set_inputs(1'b1, 14'sd100, 1'b0, dt_sel_t'(s));
         wait_gates(4'b0110, 100, n);
         set_inputs(1'b1, -14'sd100, 1'b0, dt_sel_t'(s));
         wait_gates(4'b1001, 100, n);
         check_count(cnt_t'(n - 2), DT_TABLE[s], "dead time");
      end

      chk_on = 1'b0;
      $display("errors: %0d mismatches, %0d other failures", n_mis, n_other);
      if (n_mis + n_other == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
